/* source/fetch_pkg.sv */
// Fetch stage package
// Shared sizes, address and instruction types, core-bus answer codes
// and the fetch state encoding used across the fetch stage blocks
`default_nettype none

package fetch_pkg;

  // L0 instruction buffer depth
  localparam int L0_SLOTS = 2;

  // Reads allowed in flight on the core bus
  localparam int MAX_OT = 4;

  // Instruction address
  typedef logic [31:0] pc_t;

  // Raw instruction word as returned by memory
  typedef logic [31:0] instr_raw_t;

  // Core-bus answer code
  typedef enum logic {
    CB_OKAY  = 1'b0,
    CB_ERROR = 1'b1
  } cb_resp_t;

  // Fetch sequencing states
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    FETCH_CLEAR = 2'd1,
    FETCH_RUN   = 2'd2
  } fetch_fsm_t;

endpackage : fetch_pkg

`default_nettype wire

/* source/cb_rd_if.sv */
// Core-bus read channel
// Address request and read answer, each with its own valid/ready pair.
// Answers return in request order
`default_nettype none

interface cb_rd_if;

  // Address request
  logic                  rd_addr_valid;
  fetch_pkg::pc_t        rd_addr;
  logic                  rd_addr_ready;

  // Read answer
  logic                  rd_valid;
  fetch_pkg::instr_raw_t rd_data;
  fetch_pkg::cb_resp_t   rd_resp;
  logic                  rd_ready;

  // Drives the address request
  modport issuer (
    output rd_addr_valid,
    output rd_addr,
    input  rd_addr_ready
  );

  // Takes the answers
  modport receiver (
    input  rd_valid,
    input  rd_data,
    input  rd_resp,
    output rd_ready
  );

  // Observes both handshakes
  modport monitor (
    input rd_addr_valid,
    input rd_addr,
    input rd_addr_ready,
    input rd_valid,
    input rd_data,
    input rd_resp,
    input rd_ready
  );

endinterface : cb_rd_if

`default_nettype wire

/* source/fetch_fsm.sv */
// Fetch sequencing FSM
// Finds rising edges on the start and redirect triggers, raises a
// one-cycle flush and steps through IDLE, FETCH_CLEAR and FETCH_RUN
`default_nettype none

module fetch_fsm (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   fetch_start_i,
  input  wire                   fetch_req_i,
  output logic                  flush_o,
  output logic                  use_start_o,
  output fetch_pkg::fetch_fsm_t state_o
);

  logic                  start_q;
  logic                  req_q;
  logic                  start_edge;
  logic                  req_edge;
  fetch_pkg::fetch_fsm_t state_q;
  fetch_pkg::fetch_fsm_t state_d;

  // Edge detection against the registered copies
  assign start_edge  = fetch_start_i & ~start_q;
  assign req_edge    = fetch_req_i & ~req_q;
  assign flush_o     = start_edge | req_edge;
  // Start wins when both rise together
  assign use_start_o = start_edge;
  assign state_o     = state_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::IDLE:        if (flush_o) state_d = fetch_pkg::FETCH_CLEAR;
      fetch_pkg::FETCH_CLEAR: state_d = fetch_pkg::FETCH_RUN;
      fetch_pkg::FETCH_RUN:   if (flush_o) state_d = fetch_pkg::FETCH_CLEAR;
      default:                state_d = fetch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      start_q <= 1'b0;
      req_q   <= 1'b0;
      state_q <= fetch_pkg::IDLE;
    end else begin
      start_q <= fetch_start_i;
      req_q   <= fetch_req_i;
      state_q <= state_d;
    end
  end

endmodule : fetch_fsm

`default_nettype wire

/* source/fetch_ot_counter.sv */
// Outstanding read tracker
// Counts core-bus reads in flight and keeps the drained flag, which
// stays low after a redirect until every older answer has come back
`default_nettype none

module fetch_ot_counter (
  input  wire          clk,
  input  wire          rst_i,
  cb_rd_if.monitor     bus,
  input  wire          flush_i,
  output logic         ot_full_o,
  output logic         drained_o
);

  localparam int CNT_W = $clog2(fetch_pkg::MAX_OT) + 1;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             drained_q;
  logic             drained_d;
  logic             req_taken;
  logic             ans_taken;

  assign req_taken = bus.rd_addr_valid & bus.rd_addr_ready;
  assign ans_taken = bus.rd_valid & bus.rd_ready;

  always_comb begin
    cnt_d     = cnt_q + CNT_W'(req_taken) - CNT_W'(ans_taken);
    drained_d = drained_q;
    // Reevaluate on a flush, or keep waiting for the count to empty
    if (!drained_q || flush_i) begin
      drained_d = (cnt_d == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q     <= '0;
      drained_q <= 1'b0;
    end else begin
      cnt_q     <= cnt_d;
      drained_q <= drained_d;
    end
  end

  assign ot_full_o = (cnt_q == CNT_W'(fetch_pkg::MAX_OT));
  assign drained_o = drained_q;

endmodule : fetch_ot_counter

`default_nettype wire

/* source/fetch_pc_gen.sv */
// Program counter and read request issue
// Loads the PC on a flush, steps it by one word per accepted request
// and drives a word-aligned read address on the core bus
`default_nettype none

module fetch_pc_gen (
  input  wire                   clk,
  input  wire                   rst_i,
  cb_rd_if.issuer               bus,
  input  fetch_pkg::fetch_fsm_t state_i,
  input  wire                   flush_i,
  input  wire                   use_start_i,
  input  fetch_pkg::pc_t        fetch_start_addr_i,
  input  fetch_pkg::pc_t        fetch_addr_i,
  input  wire                   buf_full_i,
  input  wire                   ot_full_i,
  input  wire                   drained_i
);

  fetch_pkg::pc_t pc_q;
  fetch_pkg::pc_t flush_addr;
  logic           pend_q;
  logic           can_issue;
  logic           req_taken;

  assign flush_addr = use_start_i ? {fetch_start_addr_i[31:2], 2'b00}
                                  : {fetch_addr_i[31:2], 2'b00};

  // New request only with buffer room, a free slot and no stale answers.
  // A request already on the bus stays up until it is taken
  assign can_issue = (state_i != fetch_pkg::IDLE) && !flush_i;

  assign bus.rd_addr_valid = can_issue &&
                             (pend_q || (!buf_full_i && !ot_full_i && drained_i));
  assign bus.rd_addr       = pc_q;

  assign req_taken = bus.rd_addr_valid & bus.rd_addr_ready;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= '0;
    end else if (flush_i) begin
      pc_q <= flush_addr;
    end else if (req_taken) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // Request shown but not yet taken
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= bus.rd_addr_valid & ~bus.rd_addr_ready;
    end
  end

endmodule : fetch_pc_gen

`default_nettype wire

/* source/fetch_resp_trap.sv */
// Read answer handling and access fault
// Writes good instruction words into the L0 buffer and turns error
// answers into a one-cycle trap carrying the address of the word
`default_nettype none

module fetch_resp_trap (
  input  wire                   clk,
  input  wire                   rst_i,
  cb_rd_if.receiver             bus,
  input  fetch_pkg::fetch_fsm_t state_i,
  input  wire                   flush_i,
  input  wire                   use_start_i,
  input  fetch_pkg::pc_t        fetch_start_addr_i,
  input  fetch_pkg::pc_t        fetch_addr_i,
  input  wire                   drained_i,
  input  wire                   buf_full_i,
  output logic                  wr_o,
  output fetch_pkg::instr_raw_t wdata_o,
  output logic                  trap_active_o,
  output fetch_pkg::pc_t        trap_addr_o
);

  fetch_pkg::pc_t exp_addr_q;
  logic           ans_taken;
  logic           ans_used;

  // Hold answers at the memory while the buffer has no room
  assign bus.rd_ready = ~buf_full_i;
  assign ans_taken    = bus.rd_valid & bus.rd_ready;

  // Stale answers are taken off the bus and dropped
  assign ans_used = ans_taken && drained_i && !flush_i &&
                    (state_i != fetch_pkg::FETCH_CLEAR);

  assign wr_o          = ans_used && (bus.rd_resp == fetch_pkg::CB_OKAY);
  assign wdata_o       = bus.rd_data;
  assign trap_active_o = ans_used && (bus.rd_resp == fetch_pkg::CB_ERROR);
  assign trap_addr_o   = exp_addr_q;

  // Address of the next answer to be used, follows the PC
  always_ff @(posedge clk) begin
    if (rst_i) begin
      exp_addr_q <= '0;
    end else if (flush_i) begin
      exp_addr_q <= use_start_i ? {fetch_start_addr_i[31:2], 2'b00}
                                : {fetch_addr_i[31:2], 2'b00};
    end else if (ans_used) begin
      exp_addr_q <= exp_addr_q + 32'd4;
    end
  end

endmodule : fetch_resp_trap

`default_nettype wire

/* source/fetch_l0_fifo.sv */
// L0 instruction buffer
// Small circular FIFO of instruction words with a one-cycle clear.
// Reports occupancy and full, and allows a read and a write together
`default_nettype none

module fetch_l0_fifo (
  input  wire                                  clk,
  input  wire                                  rst_i,
  input  wire                                  clear_i,
  input  wire                                  wr_i,
  input  fetch_pkg::instr_raw_t                wdata_i,
  input  wire                                  rd_i,
  output fetch_pkg::instr_raw_t                rdata_o,
  output logic                                 full_o,
  output logic [$clog2(fetch_pkg::L0_SLOTS):0] ocup_o
);

  localparam int PTR_W  = (fetch_pkg::L0_SLOTS > 1) ? $clog2(fetch_pkg::L0_SLOTS) : 1;
  localparam int OCUP_W = $clog2(fetch_pkg::L0_SLOTS) + 1;

  fetch_pkg::instr_raw_t mem [fetch_pkg::L0_SLOTS];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [OCUP_W-1:0]     ocup_q;
  logic                  do_wr;
  logic                  do_rd;

  assign full_o  = (ocup_q == OCUP_W'(fetch_pkg::L0_SLOTS));
  assign do_wr   = wr_i && !full_o;
  assign do_rd   = rd_i && (ocup_q != '0);
  assign ocup_o  = ocup_q;
  assign rdata_o = mem[rd_ptr_q];

  // Storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

  // Pointers and count, clear has priority over traffic
  always_ff @(posedge clk) begin
    if (rst_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      ocup_q   <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(fetch_pkg::L0_SLOTS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(fetch_pkg::L0_SLOTS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      ocup_q <= ocup_q + OCUP_W'(do_wr) - OCUP_W'(do_rd);
    end
  end

endmodule : fetch_l0_fifo

`default_nettype wire

/* source/fetch_top.sv */
// Instruction fetch stage
// Issues word reads on the core bus with up to four in flight, buffers
// the answers in a two-entry L0 FIFO for decode and flags access faults.
// Start and redirect triggers restart fetching at a new address
`default_nettype none

module fetch_top (
  input  wire                   clk,
  input  wire                   rst_i,
  // Start and redirect
  input  wire                   fetch_start_i,
  input  fetch_pkg::pc_t        fetch_start_addr_i,
  input  wire                   fetch_req_i,
  input  fetch_pkg::pc_t        fetch_addr_i,
  // Core-bus read channel
  output logic                  rd_addr_valid_o,
  output fetch_pkg::pc_t        rd_addr_o,
  input  wire                   rd_addr_ready_i,
  input  wire                   rd_valid_i,
  input  fetch_pkg::instr_raw_t rd_data_i,
  input  fetch_pkg::cb_resp_t   rd_resp_i,
  output logic                  rd_ready_o,
  // Decode side
  output logic                  fetch_valid_o,
  input  wire                   fetch_ready_i,
  output fetch_pkg::instr_raw_t fetch_instr_o,
  // Instruction access fault
  output logic                  trap_active_o,
  output fetch_pkg::pc_t        trap_addr_o
);

  fetch_pkg::fetch_fsm_t                state;
  fetch_pkg::instr_raw_t                wdata;
  logic [$clog2(fetch_pkg::L0_SLOTS):0] ocup;
  logic                                 flush;
  logic                                 use_start;
  logic                                 ot_full;
  logic                                 drained;
  logic                                 buf_full;
  logic                                 buf_wr;
  logic                                 buf_rd;

  cb_rd_if bus ();

  assign rd_addr_valid_o   = bus.rd_addr_valid;
  assign rd_addr_o         = bus.rd_addr;
  assign bus.rd_addr_ready = rd_addr_ready_i;
  assign bus.rd_valid      = rd_valid_i;
  assign bus.rd_data       = rd_data_i;
  assign bus.rd_resp       = rd_resp_i;
  assign rd_ready_o        = bus.rd_ready;

  // Decode sees nothing in a flush cycle
  assign fetch_valid_o = (ocup != '0) && !flush;
  assign buf_rd        = fetch_valid_o && fetch_ready_i;

  fetch_fsm u_fsm (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_start_i (fetch_start_i),
    .fetch_req_i   (fetch_req_i),
    .flush_o       (flush),
    .use_start_o   (use_start),
    .state_o       (state)
  );

  fetch_ot_counter u_ot_counter (
    .clk       (clk),
    .rst_i     (rst_i),
    .bus       (bus.monitor),
    .flush_i   (flush),
    .ot_full_o (ot_full),
    .drained_o (drained)
  );

  fetch_pc_gen u_pc_gen (
    .clk                (clk),
    .rst_i              (rst_i),
    .bus                (bus.issuer),
    .state_i            (state),
    .flush_i            (flush),
    .use_start_i        (use_start),
    .fetch_start_addr_i (fetch_start_addr_i),
    .fetch_addr_i       (fetch_addr_i),
    .buf_full_i         (buf_full),
    .ot_full_i          (ot_full),
    .drained_i          (drained)
  );

  fetch_resp_trap u_resp_trap (
    .clk                (clk),
    .rst_i              (rst_i),
    .bus                (bus.receiver),
    .state_i            (state),
    .flush_i            (flush),
    .use_start_i        (use_start),
    .fetch_start_addr_i (fetch_start_addr_i),
    .fetch_addr_i       (fetch_addr_i),
    .drained_i          (drained),
    .buf_full_i         (buf_full),
    .wr_o               (buf_wr),
    .wdata_o            (wdata),
    .trap_active_o      (trap_active_o),
    .trap_addr_o        (trap_addr_o)
  );

  fetch_l0_fifo u_l0_fifo (
    .clk     (clk),
    .rst_i   (rst_i),
    .clear_i (flush),
    .wr_i    (buf_wr),
    .wdata_i (wdata),
    .rd_i    (buf_rd),
    .rdata_o (fetch_instr_o),
    .full_o  (buf_full),
    .ocup_o  (ocup)
  );

endmodule : fetch_top

`default_nettype wire

/* verification/tb_fetch_props.sv */
// Core-bus checks for the fetch stage
// Word alignment, request hold under address back-pressure and
// the number of reads in flight, counted from the top-level ports
`default_nettype none

module tb_fetch_props (
  input wire            clk,
  input wire            rst_i,
  input wire            flush_i,
  input wire            addr_valid_i,
  input fetch_pkg::pc_t addr_i,
  input wire            addr_ready_i,
  input wire            ans_valid_i,
  input wire            ans_ready_i
);

  localparam int CNT_W = $clog2(fetch_pkg::MAX_OT) + 2;

  logic [CNT_W-1:0] ot_cnt;
  logic             hold_q;
  fetch_pkg::pc_t   addr_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ot_cnt <= '0;
      hold_q <= 1'b0;
      addr_q <= '0;
    end else begin
      ot_cnt <= ot_cnt + CNT_W'(addr_valid_i && addr_ready_i)
                       - CNT_W'(ans_valid_i && ans_ready_i);
      // Request shown but refused by the memory
      hold_q <= addr_valid_i && !addr_ready_i;
      addr_q <= addr_i;
    end
  end

  addr_aligned: assert property (@(posedge clk) disable iff (rst_i)
    addr_valid_i |-> (addr_i[1:0] == 2'b00))
    else $error("read address not word aligned");

  // A redirect may withdraw a refused request
  addr_held: assert property (@(posedge clk) disable iff (rst_i)
    (hold_q && !flush_i) |-> (addr_valid_i && (addr_i == addr_q)))
    else $error("refused read request changed before it was taken");

  ot_limit: assert property (@(posedge clk) disable iff (rst_i)
    ot_cnt <= CNT_W'(fetch_pkg::MAX_OT))
    else $error("too many reads outstanding");

endmodule : tb_fetch_props

bind fetch_top tb_fetch_props i_props (
  .clk          (clk),
  .rst_i        (rst_i),
  .flush_i      (flush),
  .addr_valid_i (rd_addr_valid_o),
  .addr_i       (rd_addr_o),
  .addr_ready_i (rd_addr_ready_i),
  .ans_valid_i  (rd_valid_i),
  .ans_ready_i  (rd_ready_o)
);

`default_nettype wire

/* verification/tb_fetch_top.sv */
// Testbench for the instruction fetch stage
// In-order memory model with random latency and address back-pressure,
// directed tests for reset, start, decode back-pressure, redirect and faults
`default_nettype none

module tb_fetch_top;

  localparam logic [31:0] DATA_KEY = 32'h13579bdf;
  localparam int          TIMEOUT  = 3000;

  logic                  clk = 1'b0;
  logic                  rst_i = 1'b1;
  logic                  fetch_start_i = 1'b0;
  fetch_pkg::pc_t        fetch_start_addr_i = '0;
  logic                  fetch_req_i = 1'b0;
  fetch_pkg::pc_t        fetch_addr_i = '0;
  logic                  rd_addr_valid_o;
  fetch_pkg::pc_t        rd_addr_o;
  logic                  rd_addr_ready_i = 1'b0;
  logic                  rd_valid_i = 1'b0;
  fetch_pkg::instr_raw_t rd_data_i = '0;
  fetch_pkg::cb_resp_t   rd_resp_i = fetch_pkg::CB_OKAY;
  logic                  rd_ready_o;
  logic                  fetch_valid_o;
  logic                  fetch_ready_i = 1'b0;
  fetch_pkg::instr_raw_t fetch_instr_o;
  logic                  trap_active_o;
  fetch_pkg::pc_t        trap_addr_o;

  // Memory model queue and test knobs
  fetch_pkg::pc_t        mem_addr_q [$];
  int                    mem_due_q [$];
  int                    cyc = 0;
  int                    dly_min = 1;
  int                    dly_max = 5;
  logic                  rand_ready = 1'b0;
  fetch_pkg::pc_t        err_lo = 32'h1;
  fetch_pkg::pc_t        err_hi = 32'h0;
  // Words taken by decode and trap addresses seen
  fetch_pkg::instr_raw_t words_q [$];
  fetch_pkg::pc_t        traps_q [$];

  fetch_top i_dut (
    .clk                (clk),
    .rst_i              (rst_i),
    .fetch_start_i      (fetch_start_i),
    .fetch_start_addr_i (fetch_start_addr_i),
    .fetch_req_i        (fetch_req_i),
    .fetch_addr_i       (fetch_addr_i),
    .rd_addr_valid_o    (rd_addr_valid_o),
    .rd_addr_o          (rd_addr_o),
    .rd_addr_ready_i    (rd_addr_ready_i),
    .rd_valid_i         (rd_valid_i),
    .rd_data_i          (rd_data_i),
    .rd_resp_i          (rd_resp_i),
    .rd_ready_o         (rd_ready_o),
    .fetch_valid_o      (fetch_valid_o),
    .fetch_ready_i      (fetch_ready_i),
    .fetch_instr_o      (fetch_instr_o),
    .trap_active_o      (trap_active_o),
    .trap_addr_o        (trap_addr_o)
  );

  always #10 clk = ~clk;

  function automatic logic in_err_range(input fetch_pkg::pc_t addr);
    return (addr >= err_lo) && (addr <= err_hi);
  endfunction

  // Memory: drive on the falling edge, then log the handshakes of this cycle
  always @(negedge clk) begin
    cyc = cyc + 1;
    rd_addr_ready_i = ($urandom % 4) != 0;
    if (mem_addr_q.size() > 0 && cyc >= mem_due_q[0]) begin
      rd_valid_i = 1'b1;
      rd_data_i  = mem_addr_q[0] ^ DATA_KEY;
      rd_resp_i  = in_err_range(mem_addr_q[0]) ? fetch_pkg::CB_ERROR : fetch_pkg::CB_OKAY;
    end else begin
      rd_valid_i = 1'b0;
      rd_data_i  = '0;
      rd_resp_i  = fetch_pkg::CB_OKAY;
    end
    #1;
    if (rd_valid_i && rd_ready_o) begin
      void'(mem_addr_q.pop_front());
      void'(mem_due_q.pop_front());
    end
    if (!rst_i && rd_addr_valid_o && rd_addr_ready_i) begin
      mem_addr_q.push_back(rd_addr_o);
      mem_due_q.push_back(cyc + $urandom_range(dly_max, dly_min));
    end
  end

  // Decode side
  always @(negedge clk) begin
    fetch_ready_i = rand_ready ? (($urandom % 2) == 0) : 1'b1;
    #1;
    if (!rst_i && fetch_valid_o && fetch_ready_i) words_q.push_back(fetch_instr_o);
    if (!rst_i && trap_active_o) traps_q.push_back(trap_addr_o);
  end

  task automatic stop_on_error();
    $display("Something failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // Rising edge on start or redirect, with the logs cleared in the flush cycle
  task automatic trigger(input logic redirect, input fetch_pkg::pc_t addr);
    @(negedge clk);
    fetch_start_i = 1'b0;
    fetch_req_i   = 1'b0;
    @(negedge clk);
    if (redirect) begin
      fetch_addr_i = addr;
      fetch_req_i  = 1'b1;
    end else begin
      fetch_start_addr_i = addr;
      fetch_start_i      = 1'b1;
    end
    words_q.delete();
    traps_q.delete();
  endtask

  task automatic wait_words(input int n);
    int t;
    t = 0;
    while (words_q.size() < n && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (words_q.size() < n) begin
      $display("Timeout: decode got %0d of %0d words", words_q.size(), n);
      stop_on_error();
    end
  endtask

  // Consecutive words from base, with the error range skipped
  task automatic check_stream(input fetch_pkg::pc_t base, input int n);
    fetch_pkg::pc_t addr;
    int             k;
    addr = base;
    for (k = 0; k < n; k++) begin
      while (in_err_range(addr)) addr = addr + 32'd4;
      check_value($sformatf("fetch_instr_o[%0d]", k), words_q[k], addr ^ DATA_KEY);
      addr = addr + 32'd4;
    end
  endtask

  task automatic test_reset();
    repeat (8) begin
      @(negedge clk);
      #1;
      check_value("fetch_valid_o", 32'(fetch_valid_o), 32'h0);
      check_value("rd_addr_valid_o", 32'(rd_addr_valid_o), 32'h0);
      check_value("trap_active_o", 32'(trap_active_o), 32'h0);
      check_value("rd_ready_o", 32'(rd_ready_o), 32'h1);
    end
  endtask

  task automatic test_stream(input logic random_ready, input fetch_pkg::pc_t base);
    rand_ready = random_ready;
    trigger(1'b0, base);
    wait_words(40);
    check_stream(base, 40);
    check_value("trap_active_o pulses", traps_q.size(), 32'h0);
    rand_ready = 1'b0;
  endtask

  task automatic test_redirect();
    dly_min = 6;
    dly_max = 10;
    trigger(1'b0, 32'h0000_3000);
    wait_words(6);
    // Unaligned target, low bits are dropped
    trigger(1'b1, 32'h0000_5002);
    wait_words(12);
    check_stream(32'h0000_5000, 12);
    dly_min = 1;
    dly_max = 5;
  endtask

  task automatic test_fault();
    int i;
    err_lo = 32'h0000_6010;
    err_hi = 32'h0000_601c;
    trigger(1'b0, 32'h0000_6000);
    wait_words(12);
    check_stream(32'h0000_6000, 12);
    check_value("trap_active_o pulses", traps_q.size(), 32'h4);
    for (i = 0; i < 4; i++) begin
      check_value("trap_addr_o", traps_q[i], err_lo + 32'(4 * i));
    end
    err_lo = 32'h1;
    err_hi = 32'h0;
  endtask

  initial begin
    void'($urandom(32'h94f1));
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    test_reset();
    test_stream(1'b0, 32'h0000_1000);
    test_stream(1'b1, 32'h0000_2000);
    test_redirect();
    test_fault();
    $display("Everything OK");
    $finish;
  end

endmodule : tb_fetch_top

`default_nettype wire

/* fetch_top.f */
source/fetch_pkg.sv
source/cb_rd_if.sv
source/fetch_fsm.sv
source/fetch_ot_counter.sv
source/fetch_pc_gen.sv
source/fetch_resp_trap.sv
source/fetch_l0_fifo.sv
source/fetch_top.sv
verification/tb_fetch_props.sv
verification/tb_fetch_top.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch stage simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_top \
  -f fetch_top.f -o sim_fetch_top
./obj_dir/sim_fetch_top
